// ==== src/usbdev_link_pkg.sv ====
// USB device link package
// Shared timing constants and the link state and event encodings
// for the full-speed link-state subsystem

package usbdev_link_pkg;

  // 48 MHz clock cycles in one microsecond
  localparam logic [5:0] TickDiv = 6'd48;
  // Samples that must agree before a filtered line changes
  localparam int unsigned FilterCycles = 6;
  // Suspend after 3 ms of idle bus
  localparam logic [11:0] SuspendTimeout = 12'd3000;
  // SE0 longer than this many microseconds is a bus reset
  localparam logic [2:0] ResetTimeout = 3'd3;
  // Frame period plus margin for host clock tolerance
  localparam logic [9:0] SofTimeout = 10'd1005;
  // Missed frames that mean the host has gone
  localparam logic [2:0] HostLostCount = 3'd4;
  // Event queue entries
  localparam int unsigned EvtDepth = 4;

  // Link state, values shared with the register view
  typedef enum logic [2:0] {
    LinkDisconnected     = 3'd0,
    LinkPowered          = 3'd1,
    LinkPoweredSuspended = 3'd2,
    LinkActive           = 3'd3,
    LinkSuspended        = 3'd4,
    LinkActiveNoSOF      = 3'd5,
    LinkResuming         = 3'd6
  } link_state_e;

  // Link events queued for software
  typedef enum logic [2:0] {
    EvtConnect, EvtDisconnect, EvtBusReset, EvtSuspend, EvtResume, EvtHostLost
  } link_evt_e;

endpackage

// ==== src/usbdev_line_filter.sv ====
// Line stability filter
// Passes a change of its input only once it has been stable
// for Cycles consecutive clock samples

module usbdev_line_filter import usbdev_link_pkg::*; #(
  // At least two samples
  parameter int unsigned Cycles = FilterCycles
) (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic filter_i,
  output logic filter_o
);

  // Recent input samples, newest in bit 0
  logic [Cycles-1:0] hist_q;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q   <= '0;
      filter_o <= 1'b0;
    end else begin
      hist_q <= {hist_q[Cycles-2:0], filter_i};
      // Follow the input only when the whole history agrees
      if (&hist_q) begin
        filter_o <= 1'b1;
      end else if (~|hist_q) begin
        filter_o <= 1'b0;
      end
    end
  end

endmodule

// ==== src/usbdev_line_cond.sv ====
// USB line conditioning
// Makes the microsecond tick and filtered SE0 and VBUS sense levels
// for the link state machine

module usbdev_line_cond import usbdev_link_pkg::*; (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_oe_i,
  input  logic usb_sense_i,
  output logic us_tick_o,
  output logic see_se0_o,
  output logic see_pwr_sense_o
);

  logic [5:0] tick_cnt_q;
  logic       line_se0_raw;

  // Modulo TickDiv counter, tick registered at the wrap
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tick_cnt_q <= '0;
      us_tick_o  <= 1'b0;
    end else begin
      us_tick_o <= (tick_cnt_q == TickDiv - 6'd1);
      if (tick_cnt_q == TickDiv - 6'd1) begin
        tick_cnt_q <= '0;
      end else begin
        tick_cnt_q <= tick_cnt_q + 6'd1;
      end
    end
  end

  // SE0 only counts while we are not driving the pins ourselves
  assign line_se0_raw = !usb_dp_i && !usb_dn_i && !usb_oe_i;

  usbdev_line_filter #(.Cycles(FilterCycles)) u_filter_se0 (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .filter_i    (line_se0_raw),
    .filter_o    (see_se0_o)
  );

  usbdev_line_filter #(.Cycles(FilterCycles)) u_filter_sense (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .filter_i    (usb_sense_i),
    .filter_o    (see_pwr_sense_o)
  );

  // Tick is a single-cycle pulse
  a_tick_pulse: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    us_tick_o |=> !us_tick_o);

endmodule

// ==== src/usbdev_linkstate.sv ====
// USB link state tracking
// Follows attach, bus reset, suspend and resume from the conditioned
// line signals, watches for missing SOFs, and encodes state changes
// into single events for the event queue

module usbdev_linkstate import usbdev_link_pkg::*; (
  input  logic        clk_48mhz_i,
  input  logic        rst_ni,
  input  logic        us_tick_i,
  input  logic        see_se0_i,
  input  logic        see_pwr_sense_i,
  input  logic        usb_pullup_en_i,
  input  logic        rx_idle_det_i,
  input  logic        rx_j_det_i,
  input  logic        sof_detected_i,
  input  logic        resume_link_active_i,
  output logic        link_disconnect_o,
  output logic        link_powered_o,
  output logic        link_reset_o,
  output logic        link_active_o,
  output logic        link_suspend_o,
  output logic        link_resume_o,
  output logic        host_lost_o,
  output logic        sof_missed_o,
  output link_state_e link_state_o,
  output logic        evt_push_o,
  output link_evt_e   evt_code_o
);

  typedef enum logic [1:0] {NoRst, RstCnt, RstPend} rst_state_e;
  typedef enum logic [1:0] {Active, InactCnt, InactPend} inac_state_e;

  link_state_e link_state_d, link_state_q;
  rst_state_e  rst_state_d, rst_state_q;
  logic [2:0]  rst_timer_d, rst_timer_q;
  inac_state_e inac_state_d, inac_state_q;
  logic [11:0] inac_timer_d, inac_timer_q;
  logic        ev_reset, ev_bus_active, ev_bus_inactive, monitor_inac;
  logic [9:0]  sof_timer_q;
  logic [2:0]  missed_sof_q;
  logic        host_lost_q;
  logic        enter_disc, enter_pwr, enter_susp;

  // Levels straight from the registered state
  assign link_disconnect_o = (link_state_q == LinkDisconnected);
  assign link_powered_o    = see_pwr_sense_i;
  assign link_active_o     = (link_state_q == LinkActive) || (link_state_q == LinkActiveNoSOF);
  assign link_suspend_o    = (link_state_q == LinkSuspended) ||
                             (link_state_q == LinkPoweredSuspended);
  assign link_state_o      = link_state_q;

  assign ev_bus_active = !rx_idle_det_i;
  // Only watch for idle while attached and not already suspended
  assign monitor_inac  = see_pwr_sense_i && ((link_state_q == LinkPowered) || link_active_o);

  ////////////////////////////////////////////////////////////////////////////
  // Main link FSM
  always_comb begin
    link_state_d  = link_state_q;
    link_resume_o = 1'b0;
    // Losing VBUS or the pull-up always means disconnected
    if (!see_pwr_sense_i || !usb_pullup_en_i) begin
      link_state_d = LinkDisconnected;
    end else begin
      unique case (link_state_q)
        LinkDisconnected: link_state_d = LinkPowered;
        LinkPowered: begin
          if (ev_reset) begin
            link_state_d = LinkActiveNoSOF;
          end else if (resume_link_active_i) begin
            // Software asks to resume after a power-down
            link_state_d = LinkResuming;
          end else if (ev_bus_inactive) begin
            link_state_d = LinkPoweredSuspended;
          end
        end
        LinkPoweredSuspended: begin
          if (ev_reset) begin
            link_state_d = LinkActiveNoSOF;
          end else if (ev_bus_active) begin
            link_resume_o = 1'b1;
            link_state_d  = LinkPowered;
          end
        end
        // Wait out resume signaling, ends on any J or a bus reset
        LinkResuming: begin
          if (rx_j_det_i || ev_reset) begin
            link_resume_o = 1'b1;
            link_state_d  = LinkActiveNoSOF;
          end
        end
        LinkActiveNoSOF: begin
          if (ev_bus_inactive) begin
            link_state_d = LinkSuspended;
          end else if (sof_detected_i) begin
            link_state_d = LinkActive;
          end
        end
        LinkActive: begin
          if (ev_bus_inactive) begin
            link_state_d = LinkSuspended;
          end else if (ev_reset) begin
            link_state_d = LinkActiveNoSOF;
          end
        end
        LinkSuspended: begin
          if (ev_reset) begin
            link_resume_o = 1'b1;
            link_state_d  = LinkActiveNoSOF;
          end else if (ev_bus_active) begin
            link_state_d = LinkResuming;
          end
        end
        default: link_state_d = LinkDisconnected;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus reset detector
  // Counts SE0 ticks, holds the reset level until SE0 ends
  always_comb begin
    rst_state_d  = rst_state_q;
    rst_timer_d  = rst_timer_q;
    ev_reset     = 1'b0;
    link_reset_o = 1'b0;
    unique case (rst_state_q)
      NoRst: begin
        if (see_se0_i) begin
          rst_state_d = RstCnt;
          rst_timer_d = '0;
        end
      end
      RstCnt: begin
        if (!see_se0_i) begin
          rst_state_d = NoRst;
        end else if (us_tick_i) begin
          if (rst_timer_q == ResetTimeout) begin
            rst_state_d = RstPend;
          end else begin
            rst_timer_d = rst_timer_q + 3'd1;
          end
        end
      end
      RstPend: begin
        link_reset_o = 1'b1;
        // Event fires on the falling edge of SE0
        if (!see_se0_i) begin
          rst_state_d = NoRst;
          ev_reset    = 1'b1;
        end
      end
      default: rst_state_d = NoRst;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Inactivity detector, one ev_bus_inactive per idle stretch
  always_comb begin
    inac_state_d    = inac_state_q;
    inac_timer_d    = inac_timer_q;
    ev_bus_inactive = 1'b0;
    unique case (inac_state_q)
      Active: begin
        inac_timer_d = '0;
        if (!ev_bus_active && monitor_inac) begin
          inac_state_d = InactCnt;
        end
      end
      InactCnt: begin
        if (ev_bus_active || !monitor_inac) begin
          inac_state_d = Active;
        end else if (us_tick_i) begin
          if (inac_timer_q == SuspendTimeout) begin
            inac_state_d    = InactPend;
            ev_bus_inactive = 1'b1;
          end else begin
            inac_timer_d = inac_timer_q + 12'd1;
          end
        end
      end
      InactPend: if (ev_bus_active || !monitor_inac) inac_state_d = Active;
      default: inac_state_d = Active;
    endcase
  end

  // SOF watchdog and missed frame count
  assign sof_missed_o = (sof_timer_q == SofTimeout);
  assign host_lost_o  = (missed_sof_q == HostLostCount);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      link_state_q <= LinkDisconnected;
      rst_state_q  <= NoRst;
      rst_timer_q  <= '0;
      inac_state_q <= Active;
      inac_timer_q <= '0;
      sof_timer_q  <= '0;
      missed_sof_q <= '0;
      host_lost_q  <= 1'b0;
    end else begin
      link_state_q <= link_state_d;
      rst_state_q  <= rst_state_d;
      rst_timer_q  <= rst_timer_d;
      inac_state_q <= inac_state_d;
      inac_timer_q <= inac_timer_d;
      host_lost_q  <= host_lost_o;
      if (sof_missed_o || sof_detected_i || !link_active_o || link_reset_o) begin
        sof_timer_q <= '0;
      end else if (us_tick_i) begin
        sof_timer_q <= sof_timer_q + 10'd1;
      end
      // Counter saturates once the host is declared lost
      if (sof_detected_i || !link_active_o || link_reset_o) begin
        missed_sof_q <= '0;
      end else if (sof_missed_o && !host_lost_o) begin
        missed_sof_q <= missed_sof_q + 3'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Event encoding, one event per cycle in priority order
  assign enter_disc = (link_state_q != LinkDisconnected) && (link_state_d == LinkDisconnected);
  assign enter_pwr  = (link_state_q == LinkDisconnected) && (link_state_d == LinkPowered);
  assign enter_susp = (link_state_q != link_state_d) &&
                      ((link_state_d == LinkSuspended) || (link_state_d == LinkPoweredSuspended));

  always_comb begin
    evt_push_o = 1'b1;
    evt_code_o = EvtConnect;
    if (enter_disc) begin
      evt_code_o = EvtDisconnect;
    end else if (ev_reset) begin
      evt_code_o = EvtBusReset;
    end else if (link_resume_o) begin
      evt_code_o = EvtResume;
    end else if (enter_susp) begin
      evt_code_o = EvtSuspend;
    end else if (enter_pwr) begin
      evt_code_o = EvtConnect;
    end else if (host_lost_o && !host_lost_q) begin
      evt_code_o = EvtHostLost;
    end else begin
      evt_push_o = 1'b0;
    end
  end

  a_state_legal: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    link_state_q inside {LinkDisconnected, LinkPowered, LinkPoweredSuspended,
      LinkActive, LinkSuspended, LinkActiveNoSOF, LinkResuming} &&
    rst_state_q inside {NoRst, RstCnt, RstPend} &&
    inac_state_q inside {Active, InactCnt, InactPend});
  // Nothing reaches the queue while the block is held in reset
  a_no_push_in_reset: assert property (@(posedge clk_48mhz_i) !rst_ni |-> !evt_push_o);
  a_resume_pulse: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    link_resume_o |=> !link_resume_o);

endmodule

// ==== src/usbdev_link_evt_fifo.sv ====
// Link event queue
// Small circular buffer of link event codes read by software,
// drops pushes when full and keeps a sticky overflow flag

module usbdev_link_evt_fifo import usbdev_link_pkg::*; (
  input  logic      clk_48mhz_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  link_evt_e code_i,
  input  logic      pop_i,
  output link_evt_e code_o,
  output logic      empty_o,
  output logic      overflow_o
);

  link_evt_e                     mem_q [EvtDepth];
  logic [$clog2(EvtDepth)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(EvtDepth):0]     count_q;
  logic                          full, do_pop, do_push;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == EvtDepth);
  // Pop on empty is ignored
  assign do_pop  = pop_i && !empty_o;
  // A pop in the same cycle frees a slot
  assign do_push = push_i && (!full || do_pop);
  assign code_o  = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_48mhz_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= code_i;
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      // Pointers wrap at the power-of-two depth
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      if (push_i && !do_push) overflow_o <= 1'b1;
    end
  end

  a_count_bound: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    count_q <= EvtDepth);

endmodule

// ==== src/usbdev_link_top.sv ====
// USB link-state subsystem top
// Line conditioning feeds the link state machine, whose events
// are buffered in a small queue for software

module usbdev_link_top import usbdev_link_pkg::*; (
  input  logic      clk_48mhz_i,
  input  logic      rst_ni,
  input  logic      usb_dp_i,
  input  logic      usb_dn_i,
  input  logic      usb_oe_i,
  input  logic      usb_sense_i,
  input  logic      usb_pullup_en_i,
  input  logic      rx_idle_det_i,
  input  logic      rx_j_det_i,
  input  logic      sof_detected_i,
  input  logic      resume_link_active_i,
  input  logic      evt_pop_i,
  output logic      link_disconnect_o,
  output logic      link_powered_o,
  output logic      link_reset_o,
  output logic      link_active_o,
  output logic      link_suspend_o,
  output logic      link_resume_o,
  output logic      host_lost_o,
  output logic      sof_missed_o,
  output link_state_e link_state_o,
  output link_evt_e evt_code_o,
  output logic      evt_empty_o,
  output logic      evt_overflow_o
);

  logic      us_tick, see_se0, see_pwr_sense, evt_push;
  link_evt_e evt_code;

  usbdev_line_cond u_line_cond (
    .clk_48mhz_i, .rst_ni, .usb_dp_i, .usb_dn_i, .usb_oe_i, .usb_sense_i,
    .us_tick_o       (us_tick),
    .see_se0_o       (see_se0),
    .see_pwr_sense_o (see_pwr_sense)
  );

  usbdev_linkstate u_linkstate (
    .clk_48mhz_i, .rst_ni,
    .us_tick_i       (us_tick),
    .see_se0_i       (see_se0),
    .see_pwr_sense_i (see_pwr_sense),
    .usb_pullup_en_i, .rx_idle_det_i, .rx_j_det_i, .sof_detected_i, .resume_link_active_i,
    .link_disconnect_o, .link_powered_o, .link_reset_o, .link_active_o, .link_suspend_o,
    .link_resume_o, .host_lost_o, .sof_missed_o, .link_state_o,
    .evt_push_o      (evt_push),
    .evt_code_o      (evt_code)
  );

  // Reader side belongs to the register block
  usbdev_link_evt_fifo u_evt_fifo (
    .clk_48mhz_i, .rst_ni,
    .push_i     (evt_push),
    .code_i     (evt_code),
    .pop_i      (evt_pop_i),
    .code_o     (evt_code_o),
    .empty_o    (evt_empty_o),
    .overflow_o (evt_overflow_o)
  );

endmodule

// ==== sim/tb_usbdev_link.sv ====
// USB link-state subsystem testbench
// Directed tests for attach, bus reset, SOF tracking, suspend and
// resume, disconnect and event queue overflow

module tb_usbdev_link import usbdev_link_pkg::*; ();

  // Clock cycles in one microsecond
  localparam int unsigned UsCycles   = TickDiv;
  // Tests run about 10 ms, roughly twice that before giving up
  localparam int unsigned RunCycles  = 480_000;
  localparam int unsigned CycleLimit = 2 * RunCycles + 40_000;

  logic        clk_48mhz, rst_n;
  logic        usb_dp, usb_dn, usb_oe, usb_sense, usb_pullup_en;
  logic        rx_idle_det, rx_j_det, sof_detected, resume_link_active, evt_pop;
  logic        link_disconnect, link_powered, link_reset, link_active, link_suspend;
  logic        link_resume, host_lost, sof_missed, evt_empty, evt_overflow;
  link_state_e link_state;
  link_evt_e   evt_code;
  int unsigned errors;
  int unsigned cycle_cnt;

  usbdev_link_top uut (
    .clk_48mhz_i (clk_48mhz), .rst_ni (rst_n),
    .usb_dp_i (usb_dp), .usb_dn_i (usb_dn), .usb_oe_i (usb_oe),
    .usb_sense_i (usb_sense), .usb_pullup_en_i (usb_pullup_en),
    .rx_idle_det_i (rx_idle_det), .rx_j_det_i (rx_j_det),
    .sof_detected_i (sof_detected), .resume_link_active_i (resume_link_active),
    .evt_pop_i (evt_pop),
    .link_disconnect_o (link_disconnect), .link_powered_o (link_powered),
    .link_reset_o (link_reset), .link_active_o (link_active),
    .link_suspend_o (link_suspend), .link_resume_o (link_resume),
    .host_lost_o (host_lost), .sof_missed_o (sof_missed), .link_state_o (link_state),
    .evt_code_o (evt_code), .evt_empty_o (evt_empty), .evt_overflow_o (evt_overflow)
  );

  initial begin
    clk_48mhz = 1'b0;
    forever #5 clk_48mhz = ~clk_48mhz;
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk_48mhz);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout: run did not finish within %0d cycles, %0d errors", CycleLimit, errors);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Inputs change shortly after the rising edge
  task automatic drive_cycle();
    @(posedge clk_48mhz);
    #1;
  endtask

  task automatic check_state(input string name, input link_state_e got,
                             input link_state_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_evt(input string name, input link_evt_e got, input link_evt_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  // Poll the state at each falling edge, up to a limit
  task automatic wait_state(input link_state_e exp, input int unsigned limit);
    int unsigned n;
    bit          found;
    n     = 0;
    found = 1'b0;
    while (!found && n < limit) begin
      @(negedge clk_48mhz);
      n = n + 1;
      if (link_state == exp) found = 1'b1;
    end
    if (!found) begin
      $display("Link state never reached 0x%0h within %0d cycles", exp, limit);
      errors = errors + 1;
    end
  endtask

  // Read the oldest event, then pop it for one cycle
  task automatic pop_expect(input link_evt_e exp);
    @(negedge clk_48mhz);
    check_bit("evt_empty_o", evt_empty, 1'b0);
    check_evt("evt_code_o", evt_code, exp);
    drive_cycle();
    evt_pop = 1'b1;
    drive_cycle();
    evt_pop = 1'b0;
  endtask

  task automatic expect_empty();
    @(negedge clk_48mhz);
    check_bit("evt_empty_o", evt_empty, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_connect();
    @(negedge clk_48mhz);
    check_state("link_state_o", link_state, LinkDisconnected);
    check_bit("link_disconnect_o", link_disconnect, 1'b1);
    check_bit("link_powered_o", link_powered, 1'b0);
    check_bit("link_reset_o", link_reset, 1'b0);
    check_bit("evt_empty_o", evt_empty, 1'b1);
    check_bit("evt_overflow_o", evt_overflow, 1'b0);
    drive_cycle();
    usb_sense     = 1'b1;
    usb_pullup_en = 1'b1;
    wait_state(LinkPowered, FilterCycles + 4);
    check_bit("link_powered_o", link_powered, 1'b1);
    check_bit("link_disconnect_o", link_disconnect, 1'b0);
    pop_expect(EvtConnect);
    expect_empty();
  endtask

  task automatic test_bus_reset();
    bit saw_reset;
    // Long SE0, reset level must show before release
    drive_cycle();
    usb_dp = 1'b0;
    repeat (5 * UsCycles) drive_cycle();
    @(negedge clk_48mhz);
    check_bit("link_reset_o", link_reset, 1'b1);
    drive_cycle();
    usb_dp = 1'b1;
    wait_state(LinkActiveNoSOF, FilterCycles + 4);
    check_bit("link_reset_o", link_reset, 1'b0);
    pop_expect(EvtBusReset);
    expect_empty();
    // Short SE0 is ignored
    saw_reset = 1'b0;
    drive_cycle();
    usb_dp = 1'b0;
    repeat (2 * UsCycles) begin
      @(negedge clk_48mhz);
      if (link_reset) saw_reset = 1'b1;
    end
    drive_cycle();
    usb_dp = 1'b1;
    repeat (FilterCycles + 4) begin
      @(negedge clk_48mhz);
      if (link_reset) saw_reset = 1'b1;
    end
    if (saw_reset) begin
      $display("A 2 us SE0 was taken as a bus reset");
      errors = errors + 1;
    end
    check_state("link_state_o", link_state, LinkActiveNoSOF);
    expect_empty();
  endtask

  task automatic test_sof();
    int unsigned misses;
    int unsigned n;
    drive_cycle();
    sof_detected = 1'b1;
    drive_cycle();
    sof_detected = 1'b0;
    @(negedge clk_48mhz);
    check_state("link_state_o", link_state, LinkActive);
    // Regular frames, watchdog stays quiet
    misses = 0;
    repeat (3) begin
      repeat (1000 * UsCycles - 1) begin
        @(negedge clk_48mhz);
        if (sof_missed) misses = misses + 1;
      end
      drive_cycle();
      sof_detected = 1'b1;
      drive_cycle();
      sof_detected = 1'b0;
    end
    if (misses != 0) begin
      $display("sof_missed_o pulsed %0d times with regular frames", misses);
      errors = errors + 1;
    end
    // Frames stop, count misses until the host is declared lost
    misses = 0;
    n      = 0;
    while (!host_lost && n < 5 * 1006 * UsCycles) begin
      @(negedge clk_48mhz);
      n = n + 1;
      if (sof_missed) misses = misses + 1;
    end
    if (!host_lost) begin
      $display("host_lost_o never rose after the frames stopped");
      errors = errors + 1;
    end
    if (misses != 4) begin
      $display("Counted %0d sof_missed_o pulses before host lost, expected 4", misses);
      errors = errors + 1;
    end
    check_state("link_state_o", link_state, LinkActive);
    pop_expect(EvtHostLost);
    expect_empty();
  endtask

  task automatic test_suspend_resume();
    int unsigned resumes;
    drive_cycle();
    rx_idle_det = 1'b1;
    wait_state(LinkSuspended, 3100 * UsCycles);
    check_bit("link_suspend_o", link_suspend, 1'b1);
    check_bit("link_active_o", link_active, 1'b0);
    pop_expect(EvtSuspend);
    expect_empty();
    // Bus activity starts resume signaling
    drive_cycle();
    rx_idle_det = 1'b0;
    wait_state(LinkResuming, 4);
    check_bit("link_suspend_o", link_suspend, 1'b0);
    expect_empty();
    drive_cycle();
    rx_j_det = 1'b1;
    resumes  = 0;
    @(negedge clk_48mhz);
    if (link_resume) resumes = resumes + 1;
    drive_cycle();
    rx_j_det = 1'b0;
    repeat (8) begin
      @(negedge clk_48mhz);
      if (link_resume) resumes = resumes + 1;
    end
    if (resumes != 1) begin
      $display("Saw %0d link_resume_o pulses, expected one", resumes);
      errors = errors + 1;
    end
    check_state("link_state_o", link_state, LinkActiveNoSOF);
    pop_expect(EvtResume);
    expect_empty();
  endtask

  task automatic test_disconnect_overflow();
    drive_cycle();
    usb_pullup_en = 1'b0;
    wait_state(LinkDisconnected, 4);
    check_bit("link_disconnect_o", link_disconnect, 1'b1);
    pop_expect(EvtDisconnect);
    expect_empty();
    // Five pull-up changes, the fifth event is dropped
    repeat (5) begin
      drive_cycle();
      usb_pullup_en = !usb_pullup_en;
      repeat (3) drive_cycle();
    end
    @(negedge clk_48mhz);
    check_bit("evt_overflow_o", evt_overflow, 1'b1);
    check_state("link_state_o", link_state, LinkPowered);
    pop_expect(EvtConnect);
    pop_expect(EvtDisconnect);
    pop_expect(EvtConnect);
    pop_expect(EvtDisconnect);
    expect_empty();
    check_bit("evt_overflow_o", evt_overflow, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    errors             = 0;
    rst_n              = 1'b0;
    // Line idles as J
    usb_dp             = 1'b1;
    usb_dn             = 1'b0;
    usb_oe             = 1'b0;
    usb_sense          = 1'b0;
    usb_pullup_en      = 1'b0;
    rx_idle_det        = 1'b0;
    rx_j_det           = 1'b0;
    sof_detected       = 1'b0;
    resume_link_active = 1'b0;
    evt_pop            = 1'b0;
    repeat (10) @(posedge clk_48mhz);
    #1;
    rst_n = 1'b1;

    test_connect();
    test_bus_reset();
    test_sof();
    test_suspend_resume();
    test_disconnect_overflow();

    $display("Tests done after %0d cycles, %0d errors", cycle_cnt, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== usbdev_link.f ====
src/usbdev_link_pkg.sv
src/usbdev_line_filter.sv
src/usbdev_line_cond.sv
src/usbdev_linkstate.sv
src/usbdev_link_evt_fifo.sv
src/usbdev_link_top.sv
sim/tb_usbdev_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the USB link-state testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f usbdev_link.f --top-module tb_usbdev_link

out=$(./obj_dir/Vtb_usbdev_link)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
  exit 0
fi
exit 1
